//--- Bender.yml
package:
  name: ascon_ctrl

sources:
  - include_dirs:
      - logic
    files:
      - logic/ascon_ctrl_pkg.sv
      - logic/ascon_block_intake.sv
      - logic/ascon_round_counter.sv
      - logic/ascon_phase_seq.sv
      - logic/ascon_ctrl_decode.sv
      - logic/ascon_ctrl_top.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - sim/tb_ascon_ctrl.sv

//--- logic/ascon_block_intake.sv
// input side that decides what is absorbed in a wait state
// nothing is buffered, so the source holds blk stable while ready_for_data is low
// at least one AD block is expected before the message

`include "ascon_ctrl_macros.svh"

module ascon_block_intake import ascon_ctrl_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  ascon_state_e  state,
    input  ascon_blk_t    blk,
    input  logic          round_last,
    output ascon_absorb_t absorb
);

    logic extra_pend;  // full last block seen and padding block still owed
    logic last_abs;    // final AD block (or its padding) absorbed
    logic in_wait;
    logic is_last;
    logic partial;

    assign in_wait = (state == ad_wait) || (state == msg_wait);
    assign is_last = (state == ad_wait) ? blk.last_ad : blk.eot;
    assign partial = blk.valid_bytes < `ASCON_VBYTES_W'(`ASCON_BYTES_W);

    always_comb begin
        absorb = '0;
        if (in_wait) begin
            if (extra_pend) begin  // padding goes first and the source is not read
                absorb.take      = 1'b1;
                absorb.pad_extra = 1'b1;
                absorb.msg_final = (state == msg_wait);
            end else if (blk.valid) begin
                absorb.take         = 1'b1;
                absorb.pad_in_place = is_last && partial;
                absorb.msg_final    = (state == msg_wait) && blk.eot && partial;
            end
        end
        absorb.ad_final = (state == ad_diffuse) && last_abs;  // domain separation point
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            extra_pend <= 1'b0;
            last_abs   <= 1'b0;
        end else if (state == idle) begin
            extra_pend <= 1'b0;
            last_abs   <= 1'b0;
        end else begin
            if (absorb.pad_extra) begin
                extra_pend <= 1'b0;
                if (state == ad_wait) last_abs <= 1'b1;
            end else if (absorb.take && is_last) begin
                if (!partial) extra_pend <= 1'b1;          // owe a padding block
                else if (state == ad_wait) last_abs <= 1'b1;
            end
            if ((state == ad_diffuse) && round_last) last_abs <= 1'b0;  // AD closed
        end
    end

    // owed padding and a closed AD never coexist
    a_flags_excl: assert property (@(posedge clk) disable iff (!reset_n)
        !(extra_pend && last_abs));

endmodule

//--- logic/ascon_ctrl_decode.sv
// output side: Mealy decode of the phase state into datapath strobes
// pure combinational, all outputs are valid in the same cycle as state
// ciphertext_valid marks source blocks only, never the padding block

module ascon_ctrl_decode import ascon_ctrl_pkg::*; (
    input  ascon_state_e   state,
    input  ascon_absorb_t  absorb,
    input  logic           shift_last,
    input  logic           round_last,
    output ascon_dp_ctrl_t ctrl,
    output logic           ready_for_data,
    output logic           ciphertext_valid,
    output logic           ready_tag,
    output logic           done
);

    always_comb begin
        ctrl             = '0;
        ready_for_data   = 1'b0;
        ciphertext_valid = 1'b0;
        ready_tag        = 1'b0;
        done             = 1'b0;

        // masked rounds only around init and finalization, zero in idle
        ctrl.sel_masked_round = state inside {init_load, init_shift, init_diffuse,
                                              fin_shift, fin_diffuse};

        case (state)
            init_load: begin
                ctrl.write_en      = 1'b1;  // IV || key || nonce
                ctrl.sel_init_load = 1'b1;
                ctrl.key1_load     = 1'b1;
                ctrl.key2_load     = 1'b1;
            end
            init_shift, fin_shift: begin
                ctrl.shift_en   = 1'b1;
                ctrl.shift_type = 1'b1;     // PAR bits per cycle
                ctrl.last_cycle = shift_last;
            end
            ad_shift, msg_shift: begin
                ctrl.shift_en   = 1'b1;     // PAR*shares bits per cycle
                ctrl.last_cycle = shift_last;
            end
            init_diffuse, fin_diffuse: begin
                ctrl.write_en = 1'b1;
                if (round_last) begin       // S ^= 0*||K on x3/x4
                    ctrl.sel_x3      = 1'b1;
                    ctrl.sel_x4      = 1'b1;
                    ctrl.sel_xor_key = 1'b1;
                end
                ready_tag = (state == fin_diffuse) && round_last;
            end
            ad_diffuse: begin
                ctrl.write_en = 1'b1;
                ctrl.sel_x4   = round_last && absorb.ad_final;  // x4 ^= 0*1
            end
            msg_diffuse: begin
                ctrl.write_en = 1'b1;
            end
            ad_wait, msg_wait: begin
                if (absorb.take) begin
                    ctrl.write_en        = 1'b1;
                    ctrl.sel_absorb_data = 1'b1;
                    ctrl.sel_padding     = absorb.pad_in_place || absorb.pad_extra;
                    ctrl.sel_xor_key     = absorb.msg_final;  // key into capacity
                end else begin
                    ready_for_data = 1'b1;
                end
                ciphertext_valid = (state == msg_wait) && absorb.take && !absorb.pad_extra;
            end
            done_st: begin
                done = 1'b1;
            end
            default: begin
                // idle and squeeze drive nothing
            end
        endcase
    end

endmodule

//--- logic/ascon_ctrl_macros.svh
// sizes and round counts of the ASCON controller
// step counts are derived here, so PAR and the share count only change in this file
// a masked round assumes a two-stage pipeline in the masked S-box path

`ifndef ASCON_CTRL_MACROS_SVH
`define ASCON_CTRL_MACROS_SVH

// ========================================
// datapath geometry
// ========================================
`define ASCON_WORD_W          64   // lane width in bits
`define ASCON_PAR             22   // bits per masked shift
`define ASCON_SHARES          3    // masking shares (d+1)
`define ASCON_BYTES_W         16   // bytes in one rate block
`define ASCON_VBYTES_W        5    // width of the valid-byte count, holds 0..16

// ========================================
// round and step counts
// ========================================
`define ASCON_ROUNDS_MASKED   12   // init and finalization
`define ASCON_ROUNDS_UNMASKED 8    // AD and message
`define ASCON_ROUND_W         4    // round index 0..11

// ceil(word / PAR) shifts plus two pipeline flushes
`define ASCON_MASK_STEPS ((`ASCON_WORD_W + `ASCON_PAR - 1) / `ASCON_PAR + 2)
// ceil(word / (PAR * shares)) shifts plus one
`define ASCON_NOMASK_STEPS \
    ((`ASCON_WORD_W + `ASCON_PAR * `ASCON_SHARES - 1) / (`ASCON_PAR * `ASCON_SHARES) + 1)
`define ASCON_STEP_W          3    // must hold ASCON_MASK_STEPS - 1

`endif

//--- logic/ascon_ctrl_pkg.sv
// shared types of the ASCON controller
// the state encoding is five bits, values follow declaration order

package ascon_ctrl_pkg;

`include "ascon_ctrl_macros.svh"

    // phase states, shift/diffuse pairs per phase
    typedef enum logic [4:0] {
        idle,
        init_load,
        init_shift,
        init_diffuse,
        ad_wait,
        ad_shift,
        ad_diffuse,
        msg_wait,
        msg_shift,
        msg_diffuse,
        fin_shift,
        fin_diffuse,
        squeeze,
        done_st
    } ascon_state_e;

    // request from the data source, plain levels
    typedef struct packed {
        logic                        valid;        // block present
        logic                        last_ad;      // final AD block
        logic                        eot;          // final message block
        logic [`ASCON_VBYTES_W-1:0]  valid_bytes;  // 16 = full block
    } ascon_blk_t;

    // absorb decision from the intake side
    typedef struct packed {
        logic take;          // block or pending padding absorbed this cycle
        logic pad_in_place;  // partial block, padded where it stands
        logic pad_extra;     // padding-only block
        logic ad_final;      // AD complete after this permutation
        logic msg_final;     // next phase is finalization
    } ascon_absorb_t;

    // datapath strobes, 13 bits
    typedef struct packed {
        logic write_en;          // parallel load of the state register
        logic shift_en;
        logic shift_type;        // 1: PAR bits, 0: PAR*shares bits
        logic last_cycle;        // last shift of a round, may be short
        logic key1_load;
        logic key2_load;
        logic sel_init_load;     // IV, key and nonce into the state
        logic sel_masked_round;
        logic sel_padding;
        logic sel_xor_key;       // key instead of 0*1 in the final xor
        logic sel_absorb_data;   // state ^ data block
        logic sel_x3;
        logic sel_x4;
    } ascon_dp_ctrl_t;

endpackage

//--- logic/ascon_ctrl_top.sv
// top of the ASCON sequencing controller, wiring only
// the datapath is outside, it follows ctrl cycle by cycle

module ascon_ctrl_top import ascon_ctrl_pkg::*; (
    input  logic           clk,
    input  logic           reset_n,
    input  logic           start,
    input  logic           key_valid,
    input  ascon_blk_t     blk,
    output ascon_dp_ctrl_t ctrl,
    output logic           ready_for_data,
    output logic           ciphertext_valid,
    output logic           ready_tag,
    output logic           done
);

    ascon_state_e  state;
    ascon_absorb_t absorb;
    logic          shift_last;
    logic          round_last;

    // input side
    ascon_block_intake i_block_intake (
        .clk        (clk),
        .reset_n    (reset_n),
        .state      (state),
        .blk        (blk),
        .round_last (round_last),
        .absorb     (absorb)
    );

    ascon_round_counter i_round_counter (
        .clk        (clk),
        .reset_n    (reset_n),
        .state      (state),
        .shift_last (shift_last),
        .round_last (round_last)
    );

    ascon_phase_seq i_phase_seq (
        .clk        (clk),
        .reset_n    (reset_n),
        .start      (start),
        .key_valid  (key_valid),
        .absorb     (absorb),
        .shift_last (shift_last),
        .round_last (round_last),
        .state      (state)
    );

    // output side
    ascon_ctrl_decode i_ctrl_decode (
        .state            (state),
        .absorb           (absorb),
        .shift_last       (shift_last),
        .round_last       (round_last),
        .ctrl             (ctrl),
        .ready_for_data   (ready_for_data),
        .ciphertext_valid (ciphertext_valid),
        .ready_tag        (ready_tag),
        .done             (done)
    );

endmodule

//--- logic/ascon_phase_seq.sv
// phase FSM of the controller, one register and its transition rules
// no back-pressure: a block offered outside a wait state is not seen here
// done_st holds until start is released

module ascon_phase_seq import ascon_ctrl_pkg::*; (
    input  logic          clk,
    input  logic          reset_n,
    input  logic          start,
    input  logic          key_valid,
    input  ascon_absorb_t absorb,
    input  logic          shift_last,
    input  logic          round_last,
    output ascon_state_e  state
);

    ascon_state_e state_nxt;

    // ========================================
    // next state
    // ========================================
    always_comb begin
        state_nxt = state;  // hold by default
        case (state)
            idle: begin
                if (start) state_nxt = init_load;
            end
            init_load: begin
                if (key_valid) state_nxt = init_shift;  // key sampled here
            end

            // initialization, 12 masked rounds
            init_shift: begin
                if (shift_last) state_nxt = init_diffuse;
            end
            init_diffuse: begin
                state_nxt = round_last ? ad_wait : init_shift;
            end

            // associated data
            ad_wait: begin
                if (absorb.take) state_nxt = ad_shift;
            end
            ad_shift: begin
                if (shift_last) state_nxt = ad_diffuse;
            end
            ad_diffuse: begin
                if (round_last)
                    state_nxt = absorb.ad_final ? msg_wait : ad_wait;
                else
                    state_nxt = ad_shift;
            end

            // message
            msg_wait: begin
                if (absorb.take)
                    state_nxt = absorb.msg_final ? fin_shift : msg_shift;
            end
            msg_shift: begin
                if (shift_last) state_nxt = msg_diffuse;
            end
            msg_diffuse: begin
                state_nxt = round_last ? msg_wait : msg_shift;
            end

            // finalization, 12 masked rounds
            fin_shift: begin
                if (shift_last) state_nxt = fin_diffuse;
            end
            fin_diffuse: begin
                state_nxt = round_last ? squeeze : fin_shift;
            end
            squeeze: begin
                state_nxt = done_st;  // tag leaves the datapath
            end
            done_st: begin
                if (!start) state_nxt = idle;
            end
            default: state_nxt = idle;
        endcase
    end

    // ========================================
    // state register
    // ========================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            state <= idle;
        else
            state <= state_nxt;
    end

    // the run only ends after the host has dropped start
    a_done_hold: assert property (@(posedge clk) disable iff (!reset_n)
        $past(state == done_st) && (state != done_st) |-> !$past(start));

endmodule

//--- logic/ascon_round_counter.sv
// shift-step and round counters for the permutation phases
// rounds count 0..11 masked and 4..11 unmasked, as in the ASCON round constants
// the start value is taken on the first shift cycle of each permutation

`include "ascon_ctrl_macros.svh"

module ascon_round_counter import ascon_ctrl_pkg::*; (
    input  logic         clk,
    input  logic         reset_n,
    input  ascon_state_e state,
    output logic         shift_last,
    output logic         round_last
);

    localparam logic [`ASCON_STEP_W-1:0] mask_last =
        `ASCON_STEP_W'(`ASCON_MASK_STEPS - 1);
    localparam logic [`ASCON_STEP_W-1:0] nomask_last =
        `ASCON_STEP_W'(`ASCON_NOMASK_STEPS - 1);
    localparam logic [`ASCON_ROUND_W-1:0] rnd_end =
        `ASCON_ROUND_W'(`ASCON_ROUNDS_MASKED - 1);
    localparam logic [`ASCON_ROUND_W-1:0] rnd_nomask_start =
        `ASCON_ROUND_W'(`ASCON_ROUNDS_MASKED - `ASCON_ROUNDS_UNMASKED);

    logic [`ASCON_STEP_W-1:0]  step_cnt;
    logic [`ASCON_ROUND_W-1:0] rnd_cnt;
    logic                      in_perm;  // previous cycle was a round cycle
    logic                      is_shift, is_diffuse, is_masked;
    logic [`ASCON_STEP_W-1:0]  step_limit;
    logic [`ASCON_ROUND_W-1:0] rnd_start;

    assign is_shift   = state inside {init_shift, ad_shift, msg_shift, fin_shift};
    assign is_diffuse = state inside {init_diffuse, ad_diffuse, msg_diffuse, fin_diffuse};
    assign is_masked  = state inside {init_shift, init_diffuse, fin_shift, fin_diffuse};

    assign step_limit = is_masked ? mask_last : nomask_last;
    assign rnd_start  = is_masked ? '0 : rnd_nomask_start;

    assign shift_last = is_shift && (step_cnt == step_limit);
    assign round_last = is_diffuse && (rnd_cnt == rnd_end);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            step_cnt <= '0;
            rnd_cnt  <= '0;
            in_perm  <= 1'b0;
        end else begin
            in_perm  <= is_shift || is_diffuse;
            step_cnt <= (is_shift && !shift_last) ? step_cnt + 1'b1 : '0;
            if (is_shift && !in_perm)
                rnd_cnt <= rnd_start;               // new permutation
            else if (is_diffuse)
                rnd_cnt <= round_last ? '0 : rnd_cnt + 1'b1;
        end
    end

    a_rnd_range: assert property (@(posedge clk) disable iff (!reset_n)
        rnd_cnt <= rnd_end);

endmodule

//--- sim/tb_ascon_ctrl.sv
// directed testbench for the ASCON sequencing controller without a datapath model
// expected cycle counts follow from the macros and the DUT state is never read
// inputs change 1 ns after the rising edge and outputs are sampled on the falling edge

`include "ascon_ctrl_macros.svh"

module tb_ascon_ctrl import ascon_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MASK_CYC = `ASCON_MASK_STEPS + 1;                 // shifts plus diffuse
    localparam int INIT_CYC = `ASCON_ROUNDS_MASKED * MASK_CYC + 1;   // key cycle to ad_wait
    localparam int PERM_CYC = `ASCON_ROUNDS_UNMASKED * (`ASCON_NOMASK_STEPS + 1) + 1;
    localparam int FIN_CYC  = `ASCON_ROUNDS_MASKED * MASK_CYC;       // final take to ready_tag
    localparam int RUN_OVH  = 16;                                    // start, load, squeeze, done
    localparam int WATCHDOG_CYC =
        2 * (8 + 4 * RUN_OVH + 3 * (INIT_CYC + FIN_CYC) + 7 * PERM_CYC);

    // expected phase of the current cycle
    localparam int PH_OFF    = 0;
    localparam int PH_IDLE   = 1;
    localparam int PH_LOAD   = 2;
    localparam int PH_MASKED = 3;
    localparam int PH_PLAIN  = 4;

    logic           clk;
    logic           reset_n;
    logic           start;
    logic           key_valid;
    ascon_blk_t     blk;
    ascon_dp_ctrl_t ctrl;
    logic           ready_for_data, ciphertext_valid, ready_tag, done;

    int errors, checks;
    int cv_cnt, tag_cnt;  // pulses seen in the current run
    int phase;

    ascon_ctrl_top i_ascon_ctrl_top (
        .clk              (clk),
        .reset_n          (reset_n),
        .start            (start),
        .key_valid        (key_valid),
        .blk              (blk),
        .ctrl             (ctrl),
        .ready_for_data   (ready_for_data),
        .ciphertext_valid (ciphertext_valid),
        .ready_tag        (ready_tag),
        .done             (done)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;  // 10 ns period

    // ========================================
    // helpers
    // ========================================
    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic next_cycle();  // to the drive point of the next cycle
        @(posedge clk);
        #1;
    endtask

    function automatic ascon_blk_t make_blk(input logic la, input logic e, input int nb);
        ascon_blk_t b;
        b.valid       = 1'b1;
        b.last_ad     = la;
        b.eot         = e;
        b.valid_bytes = `ASCON_VBYTES_W'(nb);
        return b;
    endfunction

    // strobes that only depend on the phase and are checked every cycle
    always @(negedge clk) begin
        if (reset_n && phase != PH_OFF) begin
            cv_cnt  += int'(ciphertext_valid);
            tag_cnt += int'(ready_tag);
            expect_eq("ctrl.sel_masked_round", ctrl.sel_masked_round,
                      phase == PH_LOAD || phase == PH_MASKED);
            expect_eq("ctrl.sel_init_load", ctrl.sel_init_load, phase == PH_LOAD);
            expect_eq("ctrl.key1_load", ctrl.key1_load, phase == PH_LOAD);
            expect_eq("ctrl.key2_load", ctrl.key2_load, phase == PH_LOAD);
            if (phase == PH_IDLE) begin  // everything quiet in idle
                expect_eq("ctrl", ctrl, '0);
                expect_eq("status", {ready_for_data, ciphertext_valid, ready_tag, done}, '0);
            end
        end
    end

    // ========================================
    // run phases
    // ========================================
    task automatic start_run();
        cv_cnt  = 0;
        tag_cnt = 0;
        next_cycle();
        start = 1'b1;                 // still idle in this cycle
        @(negedge clk);
        next_cycle();
        phase = PH_LOAD;              // init_load without a key yet
        @(negedge clk);
        expect_eq("ctrl.write_en", ctrl.write_en, 1'b1);
        next_cycle();
        key_valid = 1'b1;             // load holds until the key is seen
        @(negedge clk);
        expect_eq("ctrl.write_en", ctrl.write_en, 1'b1);
        wait_ready(INIT_CYC, PH_MASKED, 3'b111, "init");
    endtask

    // one block taken in the current wait state
    task automatic send_block(input logic la, input logic e, input int nb, input logic cv);
        next_cycle();
        blk = make_blk(la, e, nb);
        @(negedge clk);
        expect_eq("ready_for_data", ready_for_data, 1'b0);
        expect_eq("ctrl.sel_absorb_data", ctrl.sel_absorb_data, 1'b1);
        expect_eq("ctrl.sel_padding", ctrl.sel_padding, (la || e) && nb < `ASCON_BYTES_W);
        expect_eq("ciphertext_valid", ciphertext_valid, cv);
    endtask

    // cycles from the take to ready_for_data
    // last_sel is {x3, x4, xor_key} of the last diffuse
    task automatic wait_ready(input int expected, input int ph, input logic [2:0] last_sel,
                              input string what);
        int n;
        logic [2:0] prev_sel;
        n = 0;
        prev_sel = '0;
        do begin
            next_cycle();
            blk.valid = 1'b0;
            n++;
            phase = (n < expected) ? ph : PH_PLAIN;
            @(negedge clk);
            if (!ready_for_data) prev_sel = {ctrl.sel_x3, ctrl.sel_x4, ctrl.sel_xor_key};
        end while (!ready_for_data && n < 4 * expected);
        assert (ready_for_data) else begin
            errors++;
            $display("timeout: ready_for_data never rose after %s", what);
        end
        if (ready_for_data) begin
            expect_eq({what, " cycles"}, n, expected);
            expect_eq({what, " last diffuse x3/x4/key"}, prev_sel, last_sel);
        end
    endtask

    // cycles from the final take to ready_tag where the first plain_cyc cycles are unmasked
    task automatic wait_tag(input int expected, input int plain_cyc);
        int n;
        n = 0;
        do begin
            next_cycle();
            blk.valid = 1'b0;
            n++;
            phase = (n <= plain_cyc) ? PH_PLAIN : PH_MASKED;
            @(negedge clk);
        end while (!ready_tag && n < 4 * expected);
        assert (ready_tag) else begin
            errors++;
            $display("timeout: ready_tag never rose during finalization");
        end
        if (ready_tag) begin
            expect_eq("tag cycles", n, expected);
            expect_eq("tag x3/x4/key", {ctrl.sel_x3, ctrl.sel_x4, ctrl.sel_xor_key}, 3'b111);
        end
    endtask

    task automatic finish_run(input int exp_cv);
        next_cycle();
        phase = PH_PLAIN;             // squeeze
        @(negedge clk);
        expect_eq("done", done, 1'b0);
        repeat (4) begin              // done holds with start high
            next_cycle();
            @(negedge clk);
            expect_eq("done", done, 1'b1);
        end
        next_cycle();
        start     = 1'b0;
        key_valid = 1'b0;
        @(negedge clk);
        expect_eq("done", done, 1'b1);
        next_cycle();
        phase = PH_IDLE;              // back in idle one cycle later
        @(negedge clk);
        expect_eq("done", done, 1'b0);
        expect_eq("ciphertext_valid pulses", cv_cnt, exp_cv);
        expect_eq("ready_tag pulses", tag_cnt, 1);
    endtask

    // ========================================
    // directed tests
    // ========================================
    task automatic idle_quiet();
        blk       = make_blk(1'b1, 1'b1, `ASCON_BYTES_W);  // ignored outside wait states
        key_valid = 1'b1;
        repeat (4) begin
            next_cycle();
            @(negedge clk);
        end
        next_cycle();
        blk       = '0;
        key_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic partial_run();
        int nb;
        nb = $urandom % `ASCON_BYTES_W;
        start_run();
        send_block(1'b1, 1'b0, nb, 1'b0);
        wait_ready(PERM_CYC, PH_PLAIN, 3'b010, "partial AD");
        nb = $urandom % `ASCON_BYTES_W;
        send_block(1'b0, 1'b1, nb, 1'b1);  // straight to finalization
        wait_tag(FIN_CYC, 0);
        finish_run(1);
    endtask

    task automatic full_ad_run();
        int nb;
        nb = $urandom % `ASCON_BYTES_W;
        start_run();
        send_block(1'b1, 1'b0, `ASCON_BYTES_W, 1'b0);
        wait_ready(2 * PERM_CYC, PH_PLAIN, 3'b010, "full AD plus padding");
        send_block(1'b0, 1'b1, nb, 1'b1);
        wait_tag(FIN_CYC, 0);
        finish_run(1);
    endtask

    task automatic three_msg_run();
        int nb;
        nb = $urandom % `ASCON_BYTES_W;
        start_run();
        send_block(1'b1, 1'b0, nb, 1'b0);
        wait_ready(PERM_CYC, PH_PLAIN, 3'b010, "partial AD");
        repeat (2) begin
            send_block(1'b0, 1'b0, `ASCON_BYTES_W, 1'b1);
            wait_ready(PERM_CYC, PH_PLAIN, 3'b000, "message block");
        end
        send_block(1'b0, 1'b1, `ASCON_BYTES_W, 1'b1);  // full eot owes a padding block
        wait_tag(PERM_CYC + FIN_CYC, PERM_CYC);
        finish_run(3);
    endtask

    // ========================================
    // main sequence and watchdog
    // ========================================
    initial begin
        void'($urandom(32'hf11da6ea));
        reset_n   = 1'b0;
        start     = 1'b0;
        key_valid = 1'b0;
        blk       = '0;
        phase     = PH_OFF;
        errors    = 0;
        checks    = 0;
        cv_cnt    = 0;
        tag_cnt   = 0;
        repeat (8) @(posedge clk);
        #1;
        reset_n = 1'b1;
        phase   = PH_IDLE;
        idle_quiet();
        partial_run();
        full_ad_run();
        three_msg_run();
        repeat (2) next_cycle();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYC) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYC);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- sources.f
+incdir+logic
logic/ascon_ctrl_pkg.sv
logic/ascon_block_intake.sv
logic/ascon_round_counter.sv
logic/ascon_phase_seq.sv
logic/ascon_ctrl_decode.sv
logic/ascon_ctrl_top.sv
sim/tb_ascon_ctrl.sv
